/* rtl/cpu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module cpu (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire cpu_pkg::word_t    write_address,  // Program load byte address
   input  wire logic [7:0]        write_data,
   input  wire logic              write_enable,   // Only while in reset
   input  wire cpu_pkg::reg_id_t  dbg_reg_id,
   output cpu_pkg::word_t         dbg_reg_data,
   output logic                   debug_flush,
   output logic                   debug_is_bj
);

   import cpu_pkg::*;

   logic [`IMEM_AW-1:0] imem_index;
   instr_t              imem_data;
   logic                load_stall;
   logic                redirect;
   word_t               redirect_pc;

   if_id_if  if_id ();
   id_ex_if  id_ex ();
   ex_mem_if ex_mem ();
   mem_wb_if mem_wb ();

   program_memory i_program_memory (
      .clk(clk), .write_address(write_address), .write_data(write_data),
      .write_enable(write_enable), .read_index(imem_index), .read_data(imem_data)
   );

   fetch_stage i_fetch_stage (
      .clk(clk), .rst_n(rst_n), .imem_index(imem_index), .imem_data(imem_data),
      .load_stall(load_stall), .redirect(redirect), .redirect_pc(redirect_pc),
      .if_id(if_id.fetch)
   );

   decode_stage i_decode_stage (
      .clk(clk), .rst_n(rst_n), .if_id(if_id.decode), .wb(mem_wb.sink),
      .redirect(redirect), .load_stall(load_stall), .dbg_reg_id(dbg_reg_id),
      .dbg_reg_data(dbg_reg_data), .id_ex(id_ex.decode)
   );

   execute_stage i_execute_stage (
      .clk(clk), .rst_n(rst_n), .id_ex(id_ex.execute), .wb(mem_wb.sink),
      .redirect(redirect), .redirect_pc(redirect_pc), .ex_mem(ex_mem.execute)
   );

   mem_stage i_mem_stage (
      .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem.memory), .mem_wb(mem_wb.source)
   );

   assign debug_flush = redirect;                           // Flush pulse
   assign debug_is_bj = id_ex.is_branch || id_ex.is_jump;   // Branch or jump in execute

endmodule

`default_nettype wire

/* rtl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Program memory depth in words
`define IMEM_WORDS 256
// Data memory depth in words
`define DMEM_WORDS 64
// Program word index width
`define IMEM_AW 8
// Data word index width
`define DMEM_AW 6

`endif

/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] word_t;    // Data word or byte address
   typedef logic [31:0] instr_t;   // Raw instruction
   typedef logic [4:0]  reg_id_t;  // Register number
   typedef logic [3:0]  alu_op_t;  // ALU operation code

   localparam alu_op_t ALU_ADD   = 4'd0;
   localparam alu_op_t ALU_SUB   = 4'd1;
   localparam alu_op_t ALU_AND   = 4'd2;
   localparam alu_op_t ALU_OR    = 4'd3;
   localparam alu_op_t ALU_XOR   = 4'd4;
   localparam alu_op_t ALU_SLT   = 4'd5;  // Signed compare
   localparam alu_op_t ALU_SLL   = 4'd6;
   localparam alu_op_t ALU_SRL   = 4'd7;
   localparam alu_op_t ALU_PASSB = 4'd8;  // Operand b straight through for lui

   localparam instr_t NOP_INSTR = 32'h0000_0013;  // addi x0 x0 0

endpackage

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
   input  wire logic              clk,
   input  wire logic              rst_n,
   if_id_if.decode                if_id,
   mem_wb_if.sink                 wb,
   input  wire logic              redirect,
   output logic                   load_stall,
   input  wire cpu_pkg::reg_id_t  dbg_reg_id,
   output cpu_pkg::word_t         dbg_reg_data,
   id_ex_if.decode                id_ex
);

   import cpu_pkg::*;

   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;

   word_t   regs [32];
   instr_t  instr;
   logic [2:0] funct3;
   reg_id_t rs1, rs2, rd;
   logic    uses_rs1, uses_rs2;
   word_t   imm;
   alu_op_t alu_op;
   logic    use_imm, reg_write, mem_read, mem_write, is_branch, branch_ne, is_jump;

   assign instr  = if_id.instr;
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign rd     = instr[11:7];

   function automatic alu_op_t funct3_op(logic [2:0] f3, logic sub);
      case (f3)
         3'b000:  return sub ? ALU_SUB : ALU_ADD;
         3'b001:  return ALU_SLL;
         3'b010:  return ALU_SLT;
         3'b100:  return ALU_XOR;
         3'b101:  return ALU_SRL;
         3'b110:  return ALU_OR;
         3'b111:  return ALU_AND;
         default: return ALU_ADD;  // sltu not supported
      endcase
   endfunction

   function automatic word_t read_reg(reg_id_t id);
      if (id == '0) return '0;
      if (wb.reg_write && wb.rd == id) return wb.result;  // Write through
      return regs[id];
   endfunction

   always_comb begin
      alu_op = ALU_ADD;
      imm = '0;
      {use_imm, reg_write, mem_read, mem_write} = '0;
      {is_branch, branch_ne, is_jump, uses_rs1, uses_rs2} = '0;  // All zero word stays a bubble
      case (instr[6:0])
         OP_REG: begin
            {uses_rs1, uses_rs2, reg_write} = 3'b111;
            alu_op = funct3_op(funct3, instr[30]);
         end
         OP_IMM: begin
            {uses_rs1, use_imm, reg_write} = 3'b111;
            imm    = {{20{instr[31]}}, instr[31:20]};          // I type with shamt in low bits
            alu_op = funct3_op(funct3, 1'b0);
         end
         OP_LUI: begin
            {use_imm, reg_write} = 2'b11;
            imm    = {instr[31:12], 12'b0};
            alu_op = ALU_PASSB;
         end
         OP_LOAD: begin
            {uses_rs1, use_imm, reg_write, mem_read} = 4'b1111;
            imm = {{20{instr[31]}}, instr[31:20]};
         end
         OP_STORE: begin
            {uses_rs1, uses_rs2, use_imm, mem_write} = 4'b1111;
            imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         end
         OP_BRANCH: begin
            {uses_rs1, uses_rs2} = 2'b11;
            is_branch = (funct3[2:1] == 2'b00);   // beq and bne only
            branch_ne = funct3[0];
            imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            alu_op = ALU_SUB;
         end
         OP_JAL: begin
            {reg_write, is_jump} = 2'b11;
            imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
         end
         default: ;
      endcase
   end

   // Load in execute feeding this instruction
   assign load_stall = id_ex.mem_read && (id_ex.rd != '0) &&
                       ((uses_rs1 && rs1 == id_ex.rd) || (uses_rs2 && rs2 == id_ex.rd));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) regs[i] <= '0;
      end else if (wb.reg_write && wb.rd != '0) begin
         regs[wb.rd] <= wb.result;   // x0 never written
      end
   end

   assign dbg_reg_data = (dbg_reg_id == '0) ? '0 : regs[dbg_reg_id];

   always_ff @(posedge clk) begin
      if (!rst_n || redirect || load_stall) begin
         id_ex.rd <= '0;
         {id_ex.use_imm, id_ex.reg_write, id_ex.mem_read, id_ex.mem_write} <= '0;  // Bubble
         {id_ex.is_branch, id_ex.branch_ne, id_ex.is_jump} <= '0;
      end else begin
         id_ex.rd <= rd;
         {id_ex.use_imm, id_ex.reg_write, id_ex.mem_read, id_ex.mem_write} <=
            {use_imm, reg_write, mem_read, mem_write};
         {id_ex.is_branch, id_ex.branch_ne, id_ex.is_jump} <= {is_branch, branch_ne, is_jump};
      end
      id_ex.pc     <= if_id.pc;
      id_ex.rs1    <= uses_rs1 ? rs1 : '0;   // Unused fields never forward
      id_ex.rs2    <= uses_rs2 ? rs2 : '0;
      id_ex.data1  <= read_reg(rs1);
      id_ex.data2  <= read_reg(rs2);
      id_ex.imm    <= imm;
      id_ex.alu_op <= alu_op;
   end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
   input  wire logic          clk,
   input  wire logic          rst_n,
   id_ex_if.execute           id_ex,
   mem_wb_if.sink             wb,
   output logic               redirect,     // One cycle per taken branch or jump
   output cpu_pkg::word_t     redirect_pc,
   ex_mem_if.execute          ex_mem        // Read back for forwarding
);

   import cpu_pkg::*;

   word_t op_a, op_b, src2;
   word_t alu_result;
   logic  taken;

   function automatic word_t fwd(reg_id_t rs, word_t reg_data);
      if (rs == '0) return reg_data;
      if (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == rs) return ex_mem.alu_data;
      if (wb.reg_write && wb.rd == rs) return wb.result;  // Older result
      return reg_data;
   endfunction

   assign op_a = fwd(id_ex.rs1, id_ex.data1);
   assign src2 = fwd(id_ex.rs2, id_ex.data2);
   assign op_b = id_ex.use_imm ? id_ex.imm : src2;

   always_comb begin
      case (id_ex.alu_op)
         ALU_ADD:   alu_result = op_a + op_b;
         ALU_SUB:   alu_result = op_a - op_b;
         ALU_AND:   alu_result = op_a & op_b;
         ALU_OR:    alu_result = op_a | op_b;
         ALU_XOR:   alu_result = op_a ^ op_b;
         ALU_SLT:   alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_SLL:   alu_result = op_a << op_b[4:0];
         ALU_SRL:   alu_result = op_a >> op_b[4:0];
         ALU_PASSB: alu_result = op_b;
         default:   alu_result = '0;
      endcase
   end

   // Predicted not taken so any taken branch redirects
   assign taken       = id_ex.is_branch && ((op_a == src2) != id_ex.branch_ne);
   assign redirect    = taken || id_ex.is_jump;
   assign redirect_pc = id_ex.pc + id_ex.imm;   // Same target form for beq bne jal

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_mem.rd <= '0;
         {ex_mem.reg_write, ex_mem.mem_read, ex_mem.mem_write} <= '0;
      end else begin
         ex_mem.rd <= id_ex.rd;
         {ex_mem.reg_write, ex_mem.mem_read, ex_mem.mem_write} <=
            {id_ex.reg_write, id_ex.mem_read, id_ex.mem_write};
      end
      ex_mem.alu_data   <= id_ex.is_jump ? id_ex.pc + 32'd4 : alu_result;  // jal link
      ex_mem.store_data <= src2;
   end

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module fetch_stage (
   input  wire logic                clk,
   input  wire logic                rst_n,
   output logic [`IMEM_AW-1:0]      imem_index,
   input  wire cpu_pkg::instr_t     imem_data,
   input  wire logic                load_stall,   // Freeze pc and if/id
   input  wire logic                redirect,     // Taken branch or jump
   input  wire cpu_pkg::word_t      redirect_pc,
   if_id_if.fetch                   if_id
);

   import cpu_pkg::*;

   word_t pc;
   logic  at_end;  // Last program word reached

   assign imem_index = pc[`IMEM_AW+1:2];
   assign at_end     = (pc[`IMEM_AW+1:2] == {`IMEM_AW{1'b1}});

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (load_stall) begin
         pc <= pc;              // Stall wins over redirect
      end else if (redirect) begin
         pc <= redirect_pc;
      end else if (!at_end) begin
         pc <= pc + 32'd4;      // Holds at last word so pipeline drains
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || (redirect && !load_stall)) begin
         if_id.pc    <= '0;
         if_id.instr <= NOP_INSTR;   // Flush younger fetch
      end else if (!load_stall) begin
         if_id.pc    <= pc;
         if_id.instr <= imem_data;
      end
   end

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module mem_stage (
   input  wire logic  clk,
   input  wire logic  rst_n,
   ex_mem_if.memory   ex_mem,
   mem_wb_if.source   mem_wb
);

   import cpu_pkg::*;

   word_t              dmem [`DMEM_WORDS];
   logic [`DMEM_AW-1:0] index;      // Word index from byte address
   word_t              load_data;

   assign index     = ex_mem.alu_data[`DMEM_AW+1:2];
   assign load_data = dmem[index];   // Combinational read

   always_ff @(posedge clk) begin
      if (ex_mem.mem_write) dmem[index] <= ex_mem.store_data;  // Whole words only
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_wb.rd        <= '0;
         mem_wb.reg_write <= 1'b0;
      end else begin
         mem_wb.rd        <= ex_mem.rd;
         mem_wb.reg_write <= ex_mem.reg_write;
      end
      mem_wb.result <= ex_mem.mem_read ? load_data : ex_mem.alu_data;
   end

endmodule

`default_nettype wire

/* rtl/pipe_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface if_id_if;
   import cpu_pkg::*;
   word_t  pc;     // Address of instr
   instr_t instr;  // NOP after reset or redirect
   modport fetch  (output pc, instr);
   modport decode (input pc, instr);
endinterface

interface id_ex_if;
   import cpu_pkg::*;
   word_t   pc;
   reg_id_t rs1, rs2, rd;      // Zero when a source is unused
   word_t   data1, data2, imm;
   alu_op_t alu_op;
   logic    use_imm, reg_write, mem_read, mem_write;
   logic    is_branch, branch_ne, is_jump;
   modport decode  (output pc, rs1, rs2, rd, data1, data2, imm, alu_op, use_imm, reg_write,
                    mem_read, mem_write, is_branch, branch_ne, is_jump);
   modport execute (input pc, rs1, rs2, rd, data1, data2, imm, alu_op, use_imm, reg_write,
                    mem_read, mem_write, is_branch, branch_ne, is_jump);
endinterface

interface ex_mem_if;
   import cpu_pkg::*;
   reg_id_t rd;
   word_t   alu_data, store_data;  // Address for loads and stores
   logic    reg_write, mem_read, mem_write;
   modport execute (output rd, alu_data, store_data, reg_write, mem_read, mem_write);
   modport memory  (input rd, alu_data, store_data, reg_write, mem_read, mem_write);
endinterface

interface mem_wb_if;
   import cpu_pkg::*;
   reg_id_t rd;
   word_t   result;  // Load data or ALU data
   logic    reg_write;
   modport source (output rd, result, reg_write);
   modport sink   (input rd, result, reg_write);
endinterface

`default_nettype wire

/* rtl/program_memory.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module program_memory (
   input  wire logic             clk,
   input  wire cpu_pkg::word_t   write_address,  // Byte address
   input  wire logic [7:0]       write_data,
   input  wire logic             write_enable,
   input  wire logic [`IMEM_AW-1:0] read_index,  // Word index
   output cpu_pkg::instr_t       read_data
);

   logic [7:0] mem [`IMEM_WORDS*4];  // Byte storage

   initial begin
      for (int i = 0; i < `IMEM_WORDS*4; i++) mem[i] = 8'h00;  // Empty words decode as bubbles
   end

   always_ff @(posedge clk) begin
      if (write_enable) mem[write_address[`IMEM_AW+1:0]] <= write_data;  // One byte per load
   end

   assign read_data = {mem[{read_index, 2'd3}], mem[{read_index, 2'd2}],  // Little endian
                       mem[{read_index, 2'd1}], mem[{read_index, 2'd0}]};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module cpu_tb -f verilog.f -Mdir obj_dir

output=$(./obj_dir/Vcpu_tb || true)
echo "$output"
echo "$output" | grep -qx "All tests passed"

/* verification/cpu_stimulus.txt */
# L byte_address instruction_hex, loaded as four bytes; R run_cycles
# X register expected_hex; F expected_flush_count
# Program 1: forwarding chain, no flushes
L 00 00c00093 # addi x1,x0,12
L 04 ffd08113 # addi x2,x1,-3
L 08 002081b3 # add x3,x1,x2
L 0c 40308233 # sub x4,x1,x3
L 10 002242b3 # xor x5,x4,x2
L 14 0032f333 # and x6,x5,x3
L 18 001363b3 # or x7,x6,x1
L 1c 00f3f413 # andi x8,x7,15
L 20 03046493 # ori x9,x8,0x30
L 24 0ff4c513 # xori x10,x9,0xff
L 28 00022593 # slti x11,x4,0
L 2c 00419613 # slli x12,x3,4
L 30 00265693 # srli x13,x12,2
R 40
X 2 00000009
X 3 00000015
X 4 fffffff7
X 5 fffffffe
X 6 00000014
X 7 0000001c
X 10 000000c3
X 11 00000001
X 13 00000054
F 0
# Program 2: store, load and load-use stalls
L 00 12300093 # addi x1,x0,0x123
L 04 00800113 # addi x2,x0,8
L 08 00112223 # sw x1,4(x2)
L 0c 00412183 # lw x3,4(x2)
L 10 00118233 # add x4,x3,x1
L 14 00412283 # lw x5,4(x2)
L 18 00128313 # addi x6,x5,1
R 40
X 3 00000123
X 4 00000246
X 5 00000123
X 6 00000124
F 0
# Program 3: taken beq and jal
L 00 00700093 # addi x1,x0,7
L 04 00700113 # addi x2,x0,7
L 08 00208663 # beq x1,x2,+12
L 0c 00100193 # addi x3,x0,1 skipped
L 10 00100213 # addi x4,x0,1 skipped
L 14 00c002ef # jal x5,+12
L 18 00100313 # addi x6,x0,1 skipped
L 1c 00100393 # addi x7,x0,1 skipped
L 20 00200413 # addi x8,x0,2
R 40
X 3 00000000
X 4 00000000
X 5 00000018
X 6 00000000
X 7 00000000
X 8 00000002
F 2
# Program 4: bne not taken, lui, slt, sll, srl, x0
L 00 800000b7 # lui x1,0x80000
L 04 00300113 # addi x2,x0,3
L 08 00211463 # bne x2,x2,+8
L 0c 0020a1b3 # slt x3,x1,x2
L 10 002112b3 # sll x5,x2,x2
L 14 0020d333 # srl x6,x1,x2
L 18 00500013 # addi x0,x0,5
L 1c 002003b3 # add x7,x0,x2
R 40
X 0 00000000
X 1 80000000
X 3 00000001
X 5 00000018
X 6 10000000
X 7 00000003
F 0
# Program 5: countdown loop, run twice to show registers clear on reset
L 00 00400093 # addi x1,x0,4
L 04 001282b3 # add x5,x5,x1
L 08 fff08093 # addi x1,x1,-1
L 0c fe009ce3 # bne x1,x0,-8
L 10 00100313 # addi x6,x0,1
R 60
X 1 00000000
X 5 0000000a
X 6 00000001
F 3
R 60
X 5 0000000a
F 3

/* verification/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

   import cpu_pkg::*;

   logic       clk;
   logic       rst_n;
   word_t      write_address;
   logic [7:0] write_data;
   logic       write_enable;
   reg_id_t    dbg_reg_id;
   word_t      dbg_reg_data;
   logic       debug_flush;
   logic       debug_is_bj;

   logic [7:0] cmd_q [$];     // Command letters in file order
   word_t      arg_a_q [$];
   word_t      arg_b_q [$];
   word_t      loaded_q [$];  // Word addresses of the resident program
   int         flushes;       // Flush pulses in the last run
   int         checks;
   int         watchdog_cycles;

   cpu i_dut (
      .clk(clk), .rst_n(rst_n), .write_address(write_address), .write_data(write_data),
      .write_enable(write_enable), .dbg_reg_id(dbg_reg_id), .dbg_reg_data(dbg_reg_data),
      .debug_flush(debug_flush), .debug_is_bj(debug_is_bj)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;  // 20 ns period

   task automatic abort_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   // Four byte writes through the load port
   task automatic write_word(word_t addr, word_t word);
      for (int b = 0; b < 4; b++) begin
         @(negedge clk);
         write_address = addr + word_t'(b);
         write_data    = word[8*b +: 8];  // Little endian
         write_enable  = 1'b1;
      end
      @(negedge clk);
      write_enable = 1'b0;
   endtask

   task automatic hold_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (16) @(negedge clk);
   endtask

   // Old words would run after a shorter program
   task automatic erase_program();
      foreach (loaded_q[i]) write_word(loaded_q[i], '0);
      loaded_q.delete();
   endtask

   task automatic check_level(string name, logic actual, logic expected);
      checks++;
      if (actual !== expected) begin
         $display("ERR %s: got 0x%h expected 0x%h", name, actual, expected);
         abort_run();
      end
   endtask

   task automatic run_program(int cycles);
      if (rst_n) hold_reset();  // Rerun of the same program
      check_level("debug_flush", debug_flush, 1'b0);  // Both strobes quiet in reset
      check_level("debug_is_bj", debug_is_bj, 1'b0);
      @(negedge clk);
      rst_n   = 1'b1;
      flushes = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (debug_flush) begin
            flushes++;  // One cycle per taken branch or jump
            check_level("debug_is_bj", debug_is_bj, 1'b1);  // Flush needs a branch or jump
         end
      end
   endtask

   task automatic check_reg(reg_id_t id, word_t expected);
      @(negedge clk);
      dbg_reg_id = id;
      #5;  // Read settles in the low phase
      checks++;
      if (dbg_reg_data !== expected) begin
         $display("ERR dbg_reg_data x%0d: got 0x%h expected 0x%h", id, dbg_reg_data, expected);
         abort_run();
      end
   endtask

   task automatic check_flushes(int expected);
      checks++;
      if (flushes != expected) begin
         $display("ERR debug_flush count: got 0x%h expected 0x%h", flushes, expected);
         abort_run();
      end
   endtask

   task automatic read_stimulus();
      int            fd;
      int            n;
      logic [7:0]    cmd;
      word_t         a;
      word_t         b;
      logic [1023:0] rest;
      logic          done;
      fd = $fopen("verification/cpu_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Cannot open verification/cpu_stimulus.txt");
         abort_run();
      end
      done = 1'b0;
      while (!done) begin
         n = $fscanf(fd, " %c", cmd);
         if (n != 1) begin
            done = 1'b1;  // End of file
         end else if (cmd == "#") begin
            n = $fgets(rest, fd);  // Comment to end of line
         end else begin
            b = '0;
            case (cmd)
               "L":      n = $fscanf(fd, "%h %h", a, b) - 1;
               "X":      n = $fscanf(fd, "%d %h", a, b) - 1;
               "R", "F": n = $fscanf(fd, "%d", a);
               default:  n = 0;
            endcase
            if (n != 1) begin
               $display("Malformed stimulus line for command %c", cmd);
               abort_run();
            end
            cmd_q.push_back(cmd);
            arg_a_q.push_back(a);
            arg_b_q.push_back(b);
         end
      end
      $fclose(fd);
   endtask

   function automatic int watchdog_limit();
      int total;
      total = 100 + 16;  // Margin plus first reset
      foreach (cmd_q[i]) begin
         case (cmd_q[i])
            "L":     total += 12;                          // Load plus later erase
            "R":     total += int'(arg_a_q[i]) + 16 + 18;  // Run, reset and margin
            "X":     total += 2;
            default: ;
         endcase
      end
      return total;
   endfunction

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout: run exceeded %0d clock cycles", watchdog_cycles);
      abort_run();
   end

   initial begin
      rst_n           = 1'b0;
      write_address   = '0;
      write_data      = '0;
      write_enable    = 1'b0;
      dbg_reg_id      = '0;
      flushes         = 0;
      checks          = 0;
      watchdog_cycles = 0;
      read_stimulus();
      watchdog_cycles = watchdog_limit();
      repeat (16) @(negedge clk);  // Power on reset
      foreach (cmd_q[i]) begin
         case (cmd_q[i])
            "L": begin
               if (rst_n) begin  // First word of a new program
                  hold_reset();
                  erase_program();
               end
               write_word(arg_a_q[i], arg_b_q[i]);
               loaded_q.push_back(arg_a_q[i]);
            end
            "R":     run_program(int'(arg_a_q[i]));
            "X":     check_reg(reg_id_t'(arg_a_q[i]), arg_b_q[i]);
            "F":     check_flushes(int'(arg_a_q[i]));
            default: ;
         endcase
      end
      if (checks == 0) begin
         $display("No checks were found in the stimulus file");
         abort_run();
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/pipe_if.sv
rtl/program_memory.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/cpu.sv
verification/cpu_tb.sv
